// File: sim/panel_testdata.txt
# name  operation  button  hold_or_count  led_run_step(hex, - = start plus advances)
# led_idle  led_run_status
after_reset      reset_check none  50 0 1 0
step_01          press       step  12 1 1 0
step_02          press       step  14 2 1 0
step_03          press       step  16 3 1 0
step_04          press       step  12 4 1 0
step_05          press       step  13 5 1 0
step_06          press       step  18 6 1 0
step_07          press       step  12 7 1 0
step_08          press       step  20 8 1 0
step_09          press       step  12 9 1 0
step_10          press       step  15 a 1 0
step_11          press       step  12 b 1 0
step_12          press       step  17 c 1 0
step_13          press       step  12 d 1 0
step_14          press       step  14 e 1 0
step_15          press       step  12 f 1 0
step_16          press       step  16 0 1 0
step_17          press       step  12 1 1 0
glitch_run       glitch      run    5 1 1 0
glitch_step      glitch      step   6 1 1 0
glitch_stop      glitch      stop   3 1 1 0
glitch_clear     glitch      clear  7 1 1 0
run_start        press       run   14 - 0 1
run_hold         run_for     none  40 - 0 1
step_in_run      press       step  12 - 0 1
glitch_in_run    glitch      stop   5 - 0 1
glitch_run_run   glitch      run    6 - 0 1
run_more         run_for     none  24 - 0 1
run_stop         press       stop  13 - 1 0
idle_after_stop  reset_check none  30 - 1 0
clear_idle       press       clear 12 0 1 0
step_after_clear press       step  15 1 1 0
run_again        press       run   12 - 0 1
run_again_hold   run_for     none  30 - 0 1
clear_in_run     press       clear 16 0 1 0
idle_after_clear reset_check none  50 0 1 0
step_final       press       step  12 1 1 0

// File: panel_top.f
hw/panel_pkg.sv
hw/button_debouncer.sv
hw/run_control_fsm.sv
hw/step_sequencer.sv
hw/panel_top.sv
sim/panel_top_tb.sv

// File: Bender.yml
package:
  name: panel_top

sources:
  # shared package first
  - hw/panel_pkg.sv
  # button front end and control
  - hw/button_debouncer.sv
  - hw/run_control_fsm.sv
  - hw/step_sequencer.sv
  # top level
  - hw/panel_top.sv
  # testbench
  - target: simulation
    files:
      - sim/panel_top_tb.sv

// File: sim/panel_top_tb.sv
`timescale 1ns/10ps

module panel_top_tb;
    import panel_pkg::*;

    // waits and stimulus lengths in clock cycles
    localparam int WAIT_LIMIT     = 4 * (DEBOUNCE_CYCLES + 2) + 4 * RUN_PACE_CYCLES;
    localparam int RELEASE_CYCLES = DEBOUNCE_CYCLES + 6;
    localparam int GLITCH_QUIET   = DEBOUNCE_CYCLES + 8;
    localparam int COUNT_MOD      = 1 << STEP_COUNT_W;

    logic        clk;
    logic        db_resetn;
    logic        btn_run;
    logic        btn_step;
    logic        btn_stop;
    logic        btn_clear;
    logic        led_run_status;
    logic        led_idle;
    step_count_t led_run_step;
    logic        cpu_advance;

    integer seed = 32'he92b47af;
    string  cur_test = "startup";
    int     errors = 0;
    int     n_tests = 0;
    int     n_failed = 0;

    // monitor state updated once per falling edge
    event   sampled;
    int     cycle_no = 0;
    int     adv_total = 0;
    int     trans_total = 0;
    int     last_adv_cycle = 0;
    logic   run_prev = 1'b0;
    logic   paced_valid = 1'b0;

    panel_top panel_top_i (
        .clk            (clk),
        .db_resetn      (db_resetn),
        .btn_run        (btn_run),
        .btn_step       (btn_step),
        .btn_stop       (btn_stop),
        .btn_clear      (btn_clear),
        .led_run_status (led_run_status),
        .led_idle       (led_idle),
        .led_run_step   (led_run_step),
        .cpu_advance    (cpu_advance)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch in %s, %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // outputs sampled mid cycle on the falling edge
    always @(negedge clk) begin
        cycle_no++;
        if (cpu_advance) begin
            adv_total++;
            // advance computed from a running state must follow the pace
            if (run_prev && paced_valid) begin
                check_value("advance spacing", RUN_PACE_CYCLES, cycle_no - last_adv_cycle);
            end
            last_adv_cycle = cycle_no;
        end
        // one cycle step or clear states
        if (!led_idle && !led_run_status) begin
            trans_total++;
        end
        // divider restarts with each rise of running
        if (led_run_status && !run_prev) begin
            paced_valid    = 1'b1;
            last_adv_cycle = cycle_no;
        end
        if (!led_run_status) begin
            paced_valid = 1'b0;
        end
        run_prev = led_run_status;
        -> sampled;
    end

    task automatic drive_cycle(input string btn, input logic val);
        @(posedge clk);
        if (btn == "run") begin
            btn_run <= val;
        end else if (btn == "step") begin
            btn_step <= val;
        end else if (btn == "stop") begin
            btn_stop <= val;
        end else if (btn == "clear") begin
            btn_clear <= val;
        end
    endtask

    // random contact bounce always shorter than the debounce window
    task automatic bounce(input string btn);
        int len;
        len = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CYCLES - 2));
        repeat (len) drive_cycle(btn, ($random(seed) % 2) != 0);
    endtask

    task automatic press_button(input string btn, input int hold);
        bounce(btn);
        repeat (hold) drive_cycle(btn, 1'b1);
        bounce(btn);
        repeat (RELEASE_CYCLES) drive_cycle(btn, 1'b0);
    endtask

    task automatic glitch_button(input string btn, input int len);
        drive_cycle(btn, 1'b1);
        repeat (len - 1) drive_cycle(btn, ($random(seed) % 2) != 0);
        repeat (GLITCH_QUIET) drive_cycle(btn, 1'b0);
    endtask

    // end marker of a press is a lamp change or an advance
    task automatic wait_marker(input string btn, input int adv_before,
                               input int trans_before, input logic was_idle);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(sampled);
            n++;
            if (btn == "run") begin
                done = led_run_status;
            end else if (btn == "stop") begin
                done = led_idle;
            end else if (btn == "clear") begin
                done = (trans_total > trans_before) && led_idle;
            end else if (btn == "step" && was_idle) begin
                done = (adv_total > adv_before) && led_idle;
            end else begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout in %s: the %s press got no response within %0d cycles",
                     cur_test, btn, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic run_test(input string name, input string op, input string btn,
                            input int value, input string cnt_str,
                            input int e_idle, input int e_run);
        int   adv_before;
        int   trans_before;
        int   count_before;
        int   errors_before;
        int   exp_cnt;
        int   n_conv;
        logic was_idle;
        cur_test      = name;
        errors_before = errors;
        @(sampled);
        adv_before   = adv_total;
        trans_before = trans_total;
        count_before = led_run_step;
        was_idle     = led_idle;

        if (op == "reset_check") begin
            repeat (value) @(sampled);
            check_value("advances while idle", 0, adv_total - adv_before);
        end else if (op == "press") begin
            press_button(btn, value);
            wait_marker(btn, adv_before, trans_before, was_idle);
            if (btn == "step" && was_idle) begin
                check_value("advances per step", 1, adv_total - adv_before);
            end
        end else if (op == "glitch") begin
            glitch_button(btn, value);
        end else if (op == "run_for") begin
            repeat (value) @(sampled);
            check_value("advances seen while running", 1, int'(adv_total > adv_before));
        end else begin
            $display("error in %s: unknown operation %s", name, op);
            errors++;
        end

        @(sampled);
        // a dash means the starting count plus the advances seen
        if (cnt_str == "-") begin
            exp_cnt = (count_before + adv_total - adv_before) % COUNT_MOD;
        end else begin
            n_conv = $sscanf(cnt_str, "%h", exp_cnt);
            if (n_conv != 1) begin
                $display("error in %s: bad expected count %s", name, cnt_str);
                errors++;
            end
        end
        check_value("led_run_step", exp_cnt, led_run_step);
        check_value("led_idle", e_idle, led_idle);
        check_value("led_run_status", e_run, led_run_status);

        n_tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    initial begin
        int    fd;
        int    r;
        int    n_fields;
        int    value;
        int    e_idle;
        int    e_run;
        string line;
        string name;
        string op;
        string btn;
        string cnt_str;

        db_resetn = 1'b1;
        btn_run   = 1'b0;
        btn_step  = 1'b0;
        btn_stop  = 1'b0;
        btn_clear = 1'b0;
        repeat (8) @(posedge clk);
        db_resetn <= 1'b0;

        fd = $fopen("sim/panel_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the test data file sim/panel_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                // skip comments and blank lines
                if (r != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%s %s %s %d %s %d %d",
                                       name, op, btn, value, cnt_str, e_idle, e_run);
                    if (n_fields == 7) begin
                        run_test(name, op, btn, value, cnt_str, e_idle, e_run);
                    end else begin
                        $display("error: malformed test data line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/panel_top.sv
`timescale 1ns/10ps

module panel_top (
    input  logic                   clk,
    input  logic                   db_resetn,
    input  logic                   btn_run,
    input  logic                   btn_step,
    input  logic                   btn_stop,
    input  logic                   btn_clear,
    output logic                   led_run_status,
    output logic                   led_idle,
    output panel_pkg::step_count_t led_run_step,
    output logic                   cpu_advance
);
    import panel_pkg::*;

    logic run_press;
    logic step_press;
    logic stop_press;
    logic clear_press;

    logic run_enable;
    logic step_pulse;
    logic clear_pulse;

    // one debouncer per button with the clean levels unused
    button_debouncer run_db_i (
        .clk       (clk),
        .db_resetn (db_resetn),
        .raw       (btn_run),
        .level     (),
        .press     (run_press)
    );

    button_debouncer step_db_i (
        .clk       (clk),
        .db_resetn (db_resetn),
        .raw       (btn_step),
        .level     (),
        .press     (step_press)
    );

    button_debouncer stop_db_i (
        .clk       (clk),
        .db_resetn (db_resetn),
        .raw       (btn_stop),
        .level     (),
        .press     (stop_press)
    );

    button_debouncer clear_db_i (
        .clk       (clk),
        .db_resetn (db_resetn),
        .raw       (btn_clear),
        .level     (),
        .press     (clear_press)
    );

    run_control_fsm fsm_i (
        .clk            (clk),
        .db_resetn      (db_resetn),
        .run_press      (run_press),
        .step_press     (step_press),
        .stop_press     (stop_press),
        .clear_press    (clear_press),
        .run_enable     (run_enable),
        .step_pulse     (step_pulse),
        .clear_pulse    (clear_pulse),
        .led_run_status (led_run_status),
        .led_idle       (led_idle)
    );

    // advance pulses go straight to the processor clock enable
    step_sequencer seq_i (
        .clk         (clk),
        .db_resetn   (db_resetn),
        .run_enable  (run_enable),
        .step_pulse  (step_pulse),
        .clear_pulse (clear_pulse),
        .step_count  (led_run_step),
        .advance     (cpu_advance)
    );

endmodule

// File: hw/step_sequencer.sv
`timescale 1ns/10ps

module step_sequencer (
    input  logic                 clk,
    input  logic                 db_resetn,
    input  logic                 run_enable,
    input  logic                 step_pulse,
    input  logic                 clear_pulse,
    output panel_pkg::step_count_t step_count,
    output logic                 advance
);
    import panel_pkg::*;

    localparam pace_cnt_t PACE_LAST = pace_cnt_t'(RUN_PACE_CYCLES - 1);

    pace_cnt_t pace_cnt;
    logic      pace_fire;
    logic      advance_next;

    assign pace_fire    = run_enable && (pace_cnt == PACE_LAST);
    assign advance_next = pace_fire || step_pulse;

    // pace divider held at zero while stopped so every run restarts it
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            pace_cnt <= '0;
        end else if (clear_pulse || !run_enable || pace_fire) begin
            pace_cnt <= '0;
        end else begin
            pace_cnt <= pace_cnt + 1'b1;
        end
    end

    // advance pulse and the count move on the same edge
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            advance    <= 1'b0;
            step_count <= '0;
        end else if (clear_pulse) begin
            advance    <= 1'b0;
            step_count <= '0;
        end else begin
            advance <= advance_next;
            if (advance_next) begin
                // wraps 15 -> 0 by width
                step_count <= step_count + 1'b1;
            end
        end
    end

endmodule

// File: hw/run_control_fsm.sv
`timescale 1ns/10ps

module run_control_fsm (
    input  logic clk,
    input  logic db_resetn,
    input  logic run_press,
    input  logic step_press,
    input  logic stop_press,
    input  logic clear_press,
    output logic run_enable,
    output logic step_pulse,
    output logic clear_pulse,
    output logic led_run_status,
    output logic led_idle
);
    import panel_pkg::*;

    panel_state_t state;
    panel_state_t state_next;

    always_ff @(posedge clk) begin
        if (db_resetn) begin
            state <= PANEL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // clear wins in every state and run wins over step
    always_comb begin
        state_next = state;
        case (state)
            PANEL_IDLE: begin
                if (clear_press) begin
                    state_next = PANEL_CLEAR;
                end else if (run_press) begin
                    state_next = PANEL_RUN;
                end else if (step_press) begin
                    state_next = PANEL_STEP;
                end
            end
            PANEL_RUN: begin
                // run and step presses are ignored here
                if (clear_press) begin
                    state_next = PANEL_CLEAR;
                end else if (stop_press) begin
                    state_next = PANEL_IDLE;
                end
            end
            PANEL_STEP: begin
                if (clear_press) begin
                    state_next = PANEL_CLEAR;
                end else begin
                    state_next = PANEL_IDLE;
                end
            end
            PANEL_CLEAR: begin
                state_next = PANEL_IDLE;
            end
            default: begin
                state_next = PANEL_IDLE;
            end
        endcase
    end

    // commands to the sequencer
    assign run_enable  = (state == PANEL_RUN);
    assign step_pulse  = (state == PANEL_STEP);
    assign clear_pulse = (state == PANEL_CLEAR);

    // status lamps
    assign led_run_status = (state == PANEL_RUN);
    assign led_idle       = (state == PANEL_IDLE);

endmodule

// File: hw/button_debouncer.sv
`timescale 1ns/10ps

module button_debouncer (
    input  logic clk,
    input  logic db_resetn,
    input  logic raw,
    output logic level,
    output logic press
);
    import panel_pkg::*;

    localparam debounce_cnt_t STABLE_LAST = debounce_cnt_t'(DEBOUNCE_CYCLES - 1);

    logic          sync_meta;
    logic          sync_q;
    debounce_cnt_t stable_cnt;
    logic          disagree;
    logic          flip;

    // two-flop synchronizer on the async button
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
        end else begin
            sync_meta <= raw;
            sync_q    <= sync_meta;
        end
    end

    assign disagree = (sync_q != level);

    // last cycle of a full run of disagreement
    assign flip = disagree && (stable_cnt == STABLE_LAST);

    // stability counter reloads as soon as input matches the level
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            stable_cnt <= '0;
        end else if (!disagree || flip) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // clean level and its rising edge
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            level <= 1'b0;
            press <= 1'b0;
        end else begin
            press <= flip && !level;
            if (flip) begin
                level <= ~level;
            end
        end
    end

endmodule

// File: hw/panel_pkg.sv
package panel_pkg;

    // step count on the leds wraps from 15 to 0
    localparam int STEP_COUNT_W = 4;

    // cycles of stable input before the clean level follows
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    // clock cycles between advances while running
    localparam int RUN_PACE_CYCLES = 4;
    localparam int PACE_CNT_W = (RUN_PACE_CYCLES > 1) ? $clog2(RUN_PACE_CYCLES) : 1;

    typedef logic [STEP_COUNT_W-1:0]   step_count_t;
    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;
    typedef logic [PACE_CNT_W-1:0]     pace_cnt_t;

    // control states of the panel
    typedef enum logic [1:0] {
        PANEL_IDLE  = 2'd0,
        PANEL_RUN   = 2'd1,
        PANEL_STEP  = 2'd2,
        PANEL_CLEAR = 2'd3
    } panel_state_t;

endpackage
